// ==== list.f ====
logic/cache_geom_pkg.sv
logic/pmem_bus_pkg.sv
logic/cache_control.sv
logic/cache_datapath.sv
logic/cache.sv
tests/cache_checker.sv
tests/cache_tb.sv

// ==== Makefile ====
# Verilator build and run of the cache testbench.

VERILATOR ?= verilator
TOP ?= cache_tb
FILE_LIST ?= list.f
BUILD_DIR ?= build
LOG ?= $(BUILD_DIR)/sim.log
VFLAGS ?= --binary --timing --assert -j 0
FAIL_TEXT ?= Finished with errors
PASS_TEXT ?= Finished with no errors

SOURCES := $(shell cat $(FILE_LIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/cache_tb.sv ====
/*
 * Testbench for the two-way write-back cache.
 * Clock, reset, a line-addressed physical memory model, directed and
 * LFSR-driven processor requests, a cycle limit and the checker.
 */

`timescale 1ns/1ns
`default_nettype none

module cache_tb;

    localparam int s_index = 3;
    localparam int tag_bits = cache_geom_pkg::addr_bits - s_index - cache_geom_pkg::offset_bits;
    localparam int line_addr_bits = cache_geom_pkg::addr_bits - cache_geom_pkg::offset_bits;
    localparam int mem_delay = 3;
    localparam int reset_cycles = 8;
    localparam int directed_requests = 14;
    localparam int random_requests = 300;
    localparam int cycle_limit = 200 * (directed_requests + random_requests) + reset_cycles;

    logic clk;
    logic rst;
    logic mem_read;
    logic mem_write;
    logic [cache_geom_pkg::addr_bits-1:0] mem_address;
    logic [pmem_bus_pkg::be_bits-1:0] mem_byte_enable;
    logic [pmem_bus_pkg::word_bits-1:0] mem_wdata;
    logic [pmem_bus_pkg::word_bits-1:0] mem_rdata;
    logic mem_resp;
    logic pmem_read;
    logic pmem_write;
    logic [cache_geom_pkg::addr_bits-1:0] pmem_address;
    logic [pmem_bus_pkg::line_bits-1:0] pmem_wdata;
    logic [pmem_bus_pkg::line_bits-1:0] pmem_rdata;
    logic pmem_resp;
    logic stall;
    logic [31:0] miss_count;

    int data_errors;
    int traffic_errors;
    int count_errors;
    int cycles;
    int wait_count;
    logic [15:0] lfsr;

    // lines written back by the cache, others come from the fill pattern.
    logic [pmem_bus_pkg::line_bits-1:0] line_mem [logic [line_addr_bits-1:0]];

    cache #(
        .s_index(s_index)
    ) cache_inst (
        .clk(clk),
        .rst(rst),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_byte_enable(mem_byte_enable),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_resp(mem_resp),
        .pmem_read(pmem_read),
        .pmem_write(pmem_write),
        .pmem_address(pmem_address),
        .pmem_wdata(pmem_wdata),
        .pmem_rdata(pmem_rdata),
        .pmem_resp(pmem_resp),
        .stall(stall),
        .miss_count(miss_count)
    );

    cache_checker #(
        .s_index(s_index)
    ) checker_inst (
        .clk(clk),
        .rst(rst),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_byte_enable(mem_byte_enable),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_resp(mem_resp),
        .pmem_read(pmem_read),
        .pmem_write(pmem_write),
        .pmem_address(pmem_address),
        .pmem_wdata(pmem_wdata),
        .pmem_resp(pmem_resp),
        .stall(stall),
        .miss_count(miss_count),
        .data_errors(data_errors),
        .traffic_errors(traffic_errors),
        .count_errors(count_errors)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // fill pattern, distinct for every word address.
    function automatic logic [31:0] initial_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'hc6a4_93e5;
    endfunction

    function automatic logic [pmem_bus_pkg::line_bits-1:0] initial_line(
        input logic [line_addr_bits-1:0] line_addr
    );
        logic [pmem_bus_pkg::line_bits-1:0] line;
        for (int w = 0; w < pmem_bus_pkg::words_per_line; w++) begin
            line[w*32 +: 32] = initial_word({line_addr, w[2:0], 2'b00});
        end
        return line;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] make_address(input int tag, input int set, input int word);
        logic [31:0] addr;
        addr = '0;
        addr[cache_geom_pkg::addr_bits-1 -: tag_bits] = tag[tag_bits-1:0];
        addr[cache_geom_pkg::offset_bits +: s_index] = set[s_index-1:0];
        addr[2 +: 3] = word[2:0];
        return addr;
    endfunction

    // memory model, answers every request with a one-cycle response.
    initial begin
        pmem_resp = 1'b0;
        pmem_rdata = '0;
        wait_count = 0;
        forever begin
            @(posedge clk);
            #5;
            if (pmem_resp) begin
                pmem_resp = 1'b0;
                wait_count = 0;
            end else if (pmem_read || pmem_write) begin
                wait_count++;
                if (wait_count == mem_delay) begin
                    if (pmem_write) begin
                        line_mem[pmem_address[31:5]] = pmem_wdata;
                    end else if (line_mem.exists(pmem_address[31:5])) begin
                        pmem_rdata = line_mem[pmem_address[31:5]];
                    end else begin
                        pmem_rdata = initial_line(pmem_address[31:5]);
                    end
                    pmem_resp = 1'b1;
                    wait_count = 0;
                end
            end else begin
                wait_count = 0;
            end
        end
    end

    // holds the request until the cache answers.
    task automatic issue_request(input logic write, input logic [31:0] addr,
                                 input logic [3:0] be, input logic [31:0] data);
        @(posedge clk);
        #5;
        mem_read = !write;
        mem_write = write;
        mem_address = addr;
        mem_byte_enable = be;
        mem_wdata = data;
        @(negedge clk);
        while (!mem_resp) begin
            @(negedge clk);
        end
        @(posedge clk);
        #5;
        mem_read = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic run_random(input int count);
        logic [31:0] value;
        logic write;
        int tag;
        int set;
        int word;
        logic [3:0] be;
        for (int i = 0; i < count; i++) begin
            value = random_bits(1);
            write = value[0];
            tag = 16 + int'(random_bits(2) % 3);
            set = 4 + int'(random_bits(1));
            word = int'(random_bits(3));
            value = random_bits(4);
            be = value[3:0];
            value = random_bits(32);
            issue_request(write, make_address(tag, set, word), be, value);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timed out after %0d cycles waiting for the cache", cycles);
            $display("errors: %0d data, %0d memory traffic, %0d miss count",
                     data_errors, traffic_errors, count_errors);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        mem_byte_enable = '0;
        mem_wdata = '0;
        lfsr = 16'd15;
        cycles = 0;
        repeat (reset_cycles) @(posedge clk);
        #5;
        rst = 1'b0;

        // clean miss, partial write hit, then read back the merged word.
        issue_request(1'b0, make_address(1, 1, 2), 4'hf, 32'h0);
        issue_request(1'b1, make_address(1, 1, 2), 4'b0101, 32'hdead_beef);
        issue_request(1'b0, make_address(1, 1, 2), 4'hf, 32'h0);

        // fill both ways of set 2, touch the first, evict the second.
        issue_request(1'b0, make_address(2, 2, 0), 4'hf, 32'h0);
        issue_request(1'b0, make_address(3, 2, 1), 4'hf, 32'h0);
        issue_request(1'b0, make_address(2, 2, 3), 4'hf, 32'h0);
        issue_request(1'b0, make_address(4, 2, 5), 4'hf, 32'h0);
        issue_request(1'b0, make_address(2, 2, 7), 4'hf, 32'h0);

        // dirty eviction of tag 1 in set 1, then a clean one.
        issue_request(1'b0, make_address(5, 1, 0), 4'hf, 32'h0);
        issue_request(1'b0, make_address(6, 1, 4), 4'hf, 32'h0);
        issue_request(1'b0, make_address(7, 1, 6), 4'hf, 32'h0);
        issue_request(1'b0, make_address(1, 1, 2), 4'hf, 32'h0);

        // write miss allocates the line.
        issue_request(1'b1, make_address(8, 3, 0), 4'hf, 32'h1357_9bdf);
        issue_request(1'b0, make_address(8, 3, 0), 4'hf, 32'h0);

        run_random(random_requests);

        repeat (2) @(posedge clk);
        $display("errors: %0d data, %0d memory traffic, %0d miss count",
                 data_errors, traffic_errors, count_errors);
        if (data_errors + traffic_errors + count_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : cache_tb

`default_nettype wire

// ==== tests/cache_checker.sv ====
/*
 * Cache checker.
 * Watches the processor and memory ports of the cache, keeps a shadow
 * word memory and a shadow of the tags, valid, dirty and LRU bits, and
 * compares read data, line fills, write-backs and the miss count.
 */

`timescale 1ns/1ns
`default_nettype none

module cache_checker #(
    parameter int s_index = 3
) (
    input wire clk,
    input wire rst,
    input wire mem_read,
    input wire mem_write,
    input wire [cache_geom_pkg::addr_bits-1:0] mem_address,
    input wire [pmem_bus_pkg::be_bits-1:0] mem_byte_enable,
    input wire [pmem_bus_pkg::word_bits-1:0] mem_wdata,
    input wire [pmem_bus_pkg::word_bits-1:0] mem_rdata,
    input wire mem_resp,
    input wire pmem_read,
    input wire pmem_write,
    input wire [cache_geom_pkg::addr_bits-1:0] pmem_address,
    input wire [pmem_bus_pkg::line_bits-1:0] pmem_wdata,
    input wire pmem_resp,
    input wire stall,
    input wire [31:0] miss_count,
    output int data_errors,
    output int traffic_errors,
    output int count_errors
);

    localparam int addr_bits = cache_geom_pkg::addr_bits;
    localparam int offset_bits = cache_geom_pkg::offset_bits;
    localparam int tag_bits = addr_bits - s_index - offset_bits;
    localparam int num_sets = 1 << s_index;
    localparam int byte_bits = pmem_bus_pkg::byte_bits;
    localparam int word_bits = pmem_bus_pkg::word_bits;

    // processor view of memory with one entry per written word.
    logic [word_bits-1:0] shadow_mem [logic [addr_bits-3:0]];

    // shadow of the cache state is updated when a request starts.
    logic [tag_bits-1:0] tag_q [2][num_sets];
    logic [1:0][num_sets-1:0] valid_q;
    logic [1:0][num_sets-1:0] dirty_q;
    logic [num_sets-1:0] lru_q;

    logic busy;
    logic expect_miss;
    logic expect_wb;
    logic [addr_bits-1:0] wb_address;
    int fills;
    int writes;
    int predicted_misses;

    // memory contents before any write differ for every word address.
    function automatic logic [31:0] initial_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'hc6a4_93e5;
    endfunction

    // reference for the word a read must return.
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (shadow_mem.exists(addr[addr_bits-1:2])) begin
            return shadow_mem[addr[addr_bits-1:2]];
        end
        return initial_word(addr);
    endfunction

    function automatic logic [pmem_bus_pkg::line_bits-1:0] expected_line(
        input logic [31:0] addr
    );
        logic [pmem_bus_pkg::line_bits-1:0] line;
        logic [31:0] word_addr;
        for (int w = 0; w < pmem_bus_pkg::words_per_line; w++) begin
            word_addr = {addr[addr_bits-1:offset_bits], w[2:0], 2'b00};
            line[w*word_bits +: word_bits] = expected_word(word_addr);
        end
        return line;
    endfunction

    task automatic merge_write();
        logic [word_bits-1:0] word;
        word = expected_word(mem_address);
        for (int b = 0; b < pmem_bus_pkg::be_bits; b++) begin
            if (mem_byte_enable[b]) begin
                word[b*byte_bits +: byte_bits] = mem_wdata[b*byte_bits +: byte_bits];
            end
        end
        shadow_mem[mem_address[addr_bits-1:2]] = word;
    endtask

    // predict hit or miss and the victim, then apply the access to the shadow.
    task automatic start_request();
        logic [tag_bits-1:0] tag;
        logic [s_index-1:0] idx;
        logic victim;
        int way;
        tag = mem_address[addr_bits-1 -: tag_bits];
        idx = mem_address[offset_bits +: s_index];
        way = -1;
        for (int w = 0; w < 2; w++) begin
            if (valid_q[w][idx] && tag_q[w][idx] == tag) begin
                way = w;
            end
        end
        expect_miss = (way < 0);
        expect_wb = 1'b0;
        if (expect_miss) begin
            victim = lru_q[idx];
            expect_wb = valid_q[victim][idx] && dirty_q[victim][idx];
            wb_address = {tag_q[victim][idx], idx, {offset_bits{1'b0}}};
            predicted_misses++;
            tag_q[victim][idx] = tag;
            valid_q[victim][idx] = 1'b1;
            dirty_q[victim][idx] = 1'b0;
            way = int'(victim);
        end
        lru_q[idx] = (way == 0) ? 1'b1 : 1'b0;
        if (mem_write) begin
            dirty_q[way][idx] = 1'b1;
        end
        fills = 0;
        writes = 0;
        busy = 1'b1;
    endtask

    task automatic check_memory_event();
        logic [addr_bits-1:0] fill_address;
        fill_address = {mem_address[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
        if (pmem_write) begin
            writes++;
            if (!busy || !expect_wb) begin
                $display("write-back issued for a request that needs none");
                traffic_errors++;
            end else if (pmem_address != wb_address) begin
                $display("[ERROR] pmem_address: expected %h, got %h", wb_address, pmem_address);
                traffic_errors++;
            end
            if (pmem_wdata != expected_line(pmem_address)) begin
                $display("[ERROR] pmem_wdata: expected %h, got %h",
                         expected_line(pmem_address), pmem_wdata);
                data_errors++;
            end
        end
        if (pmem_read) begin
            fills++;
            if (!busy || !expect_miss) begin
                $display("line fill issued for a request that should hit");
                traffic_errors++;
            end else if (pmem_address != fill_address) begin
                $display("[ERROR] pmem_address: expected %h, got %h", fill_address, pmem_address);
                traffic_errors++;
            end
            if (writes != (expect_wb ? 1 : 0)) begin
                $display("line fill came before the dirty victim was written back");
                traffic_errors++;
            end
        end
    endtask

    task automatic finish_request();
        if (!busy) begin
            $display("processor response without a pending request");
            traffic_errors++;
        end
        if (mem_read && mem_rdata != expected_word(mem_address)) begin
            $display("[ERROR] mem_rdata at %h: expected %h, got %h",
                     mem_address, expected_word(mem_address), mem_rdata);
            data_errors++;
        end
        if (mem_write) begin
            merge_write();
        end
        if (fills != (expect_miss ? 1 : 0) || writes != (expect_wb ? 1 : 0)) begin
            $display("request at %h saw %0d fills and %0d write-backs, wrong for the shadow cache",
                     mem_address, fills, writes);
            traffic_errors++;
        end
        if (miss_count != predicted_misses) begin
            $display("[ERROR] miss_count: expected %h, got %h", predicted_misses, miss_count);
            count_errors++;
        end
        if (stall) begin
            $display("stall is high together with the processor response");
            traffic_errors++;
        end
        busy = 1'b0;
    endtask

    // outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (rst) begin
            valid_q = '0;
            dirty_q = '0;
            lru_q = '0;
            busy = 1'b0;
            predicted_misses = 0;
            if (mem_resp || stall || pmem_read || pmem_write) begin
                $display("cache drives a response or memory request during reset");
                traffic_errors++;
            end
        end else begin
            if ((mem_read || mem_write) && !busy) begin
                start_request();
            end
            // a pending request that is not yet answered holds the processor.
            if ((mem_read || mem_write) && !mem_resp && !stall) begin
                $display("stall is low while a request waits for the cache");
                traffic_errors++;
            end
            if (pmem_resp) begin
                check_memory_event();
            end
            if (mem_resp) begin
                finish_request();
            end
        end
    end

endmodule : cache_checker

`default_nettype wire

// ==== logic/cache.sv ====
/*
 * Two-way write-back cache.
 * Connects the controller FSM to the datapath arrays, between a
 * processor word port and a 256-bit physical memory line port.
 */

`timescale 1ns/1ns
`default_nettype none

module cache #(
    parameter int s_index = 3
) (
    input wire clk,
    input wire rst,
    // processor port.
    input wire mem_read,
    input wire mem_write,
    input wire [cache_geom_pkg::addr_bits-1:0] mem_address,
    input wire [pmem_bus_pkg::be_bits-1:0] mem_byte_enable,
    input wire [pmem_bus_pkg::word_bits-1:0] mem_wdata,
    output logic [pmem_bus_pkg::word_bits-1:0] mem_rdata,
    output logic mem_resp,
    // physical memory port.
    output logic pmem_read,
    output logic pmem_write,
    output logic [cache_geom_pkg::addr_bits-1:0] pmem_address,
    output logic [pmem_bus_pkg::line_bits-1:0] pmem_wdata,
    input wire [pmem_bus_pkg::line_bits-1:0] pmem_rdata,
    input wire pmem_resp,
    output logic stall,
    output logic [31:0] miss_count
);

    logic load;
    logic access_sel;
    logic load_lru;
    logic set_dirty;
    logic clear_dirty;
    logic address_sel;
    logic hit;
    logic dirty;

    cache_control control_inst (
        .clk(clk),
        .rst(rst),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .hit(hit),
        .dirty(dirty),
        .pmem_resp(pmem_resp),
        .load(load),
        .access_sel(access_sel),
        .load_lru(load_lru),
        .set_dirty(set_dirty),
        .clear_dirty(clear_dirty),
        .address_sel(address_sel),
        .pmem_read(pmem_read),
        .pmem_write(pmem_write),
        .mem_resp(mem_resp),
        .stall(stall),
        .miss_count(miss_count)
    );

    cache_datapath #(
        .s_index(s_index)
    ) datapath_inst (
        .clk(clk),
        .rst(rst),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_byte_enable(mem_byte_enable),
        .mem_write(mem_write),
        .load(load),
        .access_sel(access_sel),
        .load_lru(load_lru),
        .set_dirty(set_dirty),
        .clear_dirty(clear_dirty),
        .address_sel(address_sel),
        .pmem_rdata(pmem_rdata),
        .mem_rdata(mem_rdata),
        .pmem_address(pmem_address),
        .pmem_wdata(pmem_wdata),
        .hit(hit),
        .dirty(dirty)
    );

endmodule : cache

`default_nettype wire

// ==== logic/cache_datapath.sv ====
/*
 * Cache datapath.
 * Tag, valid, dirty, LRU and line arrays of a two-way set-associative
 * cache. Detects hits, picks the victim way from the LRU bit, merges
 * byte-enabled writes and drives the physical memory address and line.
 */

`timescale 1ns/1ns
`default_nettype none

module cache_datapath #(
    parameter int s_index = 3
) (
    input wire clk,
    input wire rst,
    input wire [cache_geom_pkg::addr_bits-1:0] mem_address,
    input wire [pmem_bus_pkg::word_bits-1:0] mem_wdata,
    input wire [pmem_bus_pkg::be_bits-1:0] mem_byte_enable,
    input wire mem_write,
    input wire load,
    input wire access_sel,
    input wire load_lru,
    input wire set_dirty,
    input wire clear_dirty,
    input wire address_sel,
    input wire [pmem_bus_pkg::line_bits-1:0] pmem_rdata,
    output logic [pmem_bus_pkg::word_bits-1:0] mem_rdata,
    output logic [cache_geom_pkg::addr_bits-1:0] pmem_address,
    output logic [pmem_bus_pkg::line_bits-1:0] pmem_wdata,
    output logic hit,
    output logic dirty
);

    localparam int tag_bits = cache_geom_pkg::addr_bits - s_index - cache_geom_pkg::offset_bits;
    localparam int num_sets = 1 << s_index;
    localparam int num_ways = cache_geom_pkg::num_ways;
    localparam int way_bits = cache_geom_pkg::way_bits;
    localparam int line_bits = pmem_bus_pkg::line_bits;
    localparam int word_bits = pmem_bus_pkg::word_bits;
    localparam int byte_bits = pmem_bus_pkg::byte_bits;

    // address fields.
    logic [tag_bits-1:0] tag;
    logic [s_index-1:0] index;
    logic [cache_geom_pkg::word_sel_bits-1:0] word_sel;

    // line and tag storage, no reset.
    logic [line_bits-1:0] data_array [num_ways][num_sets];
    logic [tag_bits-1:0] tag_array [num_ways][num_sets];

    // per-way, per-set state bits.
    logic [num_ways-1:0][num_sets-1:0] valid_q;
    logic [num_ways-1:0][num_sets-1:0] dirty_q;
    logic [num_sets-1:0] lru_q;

    logic [num_ways-1:0] way_hit;
    logic [way_bits-1:0] hit_way;
    logic [way_bits-1:0] victim;
    logic [way_bits-1:0] sel_way;
    logic [line_bits-1:0] line_cur;
    logic [line_bits-1:0] merged_line;
    logic [line_bits-1:0] new_line;
    logic [tag_bits-1:0] victim_tag;

    assign tag = mem_address[cache_geom_pkg::addr_bits-1 -: tag_bits];
    assign index = mem_address[cache_geom_pkg::offset_bits +: s_index];
    assign word_sel = mem_address[cache_geom_pkg::byte_sel_bits +: cache_geom_pkg::word_sel_bits];

    // tag compare in both ways.
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = valid_q[w][index] && (tag_array[w][index] == tag);
        end
    end

    assign hit = |way_hit;
    assign hit_way = way_hit[1] ? cache_geom_pkg::way_1 : cache_geom_pkg::way_0;

    // the LRU bit names the way to replace.
    assign victim = lru_q[index];
    assign sel_way = hit ? hit_way : victim;
    assign dirty = valid_q[victim][index] && dirty_q[victim][index];

    assign line_cur = data_array[sel_way][index];
    assign mem_rdata = line_cur[word_sel*word_bits +: word_bits];

    // byte lanes of the processor word replace their part of the line.
    always_comb begin
        merged_line = line_cur;
        for (int b = 0; b < pmem_bus_pkg::be_bits; b++) begin
            if (mem_write && mem_byte_enable[b]) begin
                merged_line[word_sel*word_bits + b*byte_bits +: byte_bits] =
                    mem_wdata[b*byte_bits +: byte_bits];
            end
        end
    end

    assign new_line = access_sel ? pmem_rdata : merged_line;

    // write-back goes to the victim's own line address.
    assign victim_tag = tag_array[victim][index];
    assign pmem_wdata = data_array[victim][index];

    always_comb begin
        if (address_sel) begin
            pmem_address = {victim_tag, index, {cache_geom_pkg::offset_bits{1'b0}}};
        end else begin
            pmem_address = {tag, index, {cache_geom_pkg::offset_bits{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_array[sel_way][index] <= new_line;
            tag_array[sel_way][index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q <= '0;
        end else begin
            if (load) begin
                valid_q[sel_way][index] <= 1'b1;
            end
            if (set_dirty) begin
                dirty_q[sel_way][index] <= 1'b1;
            end else if (clear_dirty) begin
                dirty_q[sel_way][index] <= 1'b0;
            end
            // the way just used becomes most recent.
            if (load_lru) begin
                if (sel_way == cache_geom_pkg::way_0) begin
                    lru_q[index] <= cache_geom_pkg::way_1;
                end else begin
                    lru_q[index] <= cache_geom_pkg::way_0;
                end
            end
        end
    end

    // a fill never creates a second copy of a tag within a set.
    assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

endmodule : cache_datapath

`default_nettype wire

// ==== logic/cache_control.sv ====
/*
 * Cache controller.
 * Four-state FSM that answers hits in idle, writes back a dirty victim,
 * fills the line from physical memory and then waits for the memory
 * response to drop before going back to idle. Counts misses.
 */

`timescale 1ns/1ns
`default_nettype none

module cache_control (
    input wire clk,
    input wire rst,
    input wire mem_read,
    input wire mem_write,
    input wire hit,
    input wire dirty,
    input wire pmem_resp,
    output logic load,
    output logic access_sel,
    output logic load_lru,
    output logic set_dirty,
    output logic clear_dirty,
    output logic address_sel,
    output logic pmem_read,
    output logic pmem_write,
    output logic mem_resp,
    output logic stall,
    output logic [31:0] miss_count
);

    // state encodings.
    localparam logic [1:0] idle = 2'd0;
    localparam logic [1:0] write_back = 2'd1;
    localparam logic [1:0] miss = 2'd2;
    localparam logic [1:0] buffer = 2'd3;

    logic [1:0] state;
    logic [1:0] next_state;
    logic [31:0] miss_count_next;
    logic request;

    assign request = mem_read || mem_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            miss_count <= '0;
        end else begin
            state <= next_state;
            miss_count <= miss_count_next;
        end
    end

    // state outputs.
    always_comb begin
        load = 1'b0;
        access_sel = 1'b0;
        load_lru = 1'b0;
        set_dirty = 1'b0;
        clear_dirty = 1'b0;
        address_sel = 1'b0;
        pmem_read = 1'b0;
        pmem_write = 1'b0;
        mem_resp = 1'b0;
        stall = 1'b0;
        miss_count_next = miss_count;

        case (state)
            idle: begin
                if (request) begin
                    if (hit) begin
                        load_lru = 1'b1;
                        mem_resp = 1'b1;
                        // write hit merges the word into the line.
                        if (mem_write) begin
                            load = 1'b1;
                            set_dirty = 1'b1;
                        end
                    end else begin
                        stall = 1'b1;
                        miss_count_next = miss_count + 32'd1;
                    end
                end
            end

            write_back: begin
                // victim line goes out at its own address.
                address_sel = 1'b1;
                pmem_write = 1'b1;
                stall = 1'b1;
            end

            miss: begin
                access_sel = 1'b1;
                pmem_read = 1'b1;
                stall = 1'b1;
                // the fill lands only when the line is on the bus.
                if (pmem_resp) begin
                    load = 1'b1;
                    clear_dirty = 1'b1;
                end
            end

            buffer: begin
                stall = 1'b1;
            end

            default: begin
                stall = 1'b1;
            end
        endcase
    end

    // next state.
    always_comb begin
        next_state = state;

        case (state)
            idle: begin
                if (request && !hit) begin
                    next_state = dirty ? write_back : miss;
                end
            end

            write_back: begin
                if (pmem_resp) begin
                    next_state = miss;
                end
            end

            miss: begin
                if (pmem_resp) begin
                    next_state = buffer;
                end
            end

            buffer: begin
                if (!pmem_resp) begin
                    next_state = idle;
                end
            end

            default: begin
                next_state = idle;
            end
        endcase
    end

    // only one memory transfer at a time.
    assert property (@(posedge clk) disable iff (rst) !(pmem_read && pmem_write));

    // a processor response is only given while the FSM sits in idle.
    assert property (@(posedge clk) disable iff (rst) mem_resp |-> (state == idle) && request);

endmodule : cache_control

`default_nettype wire

// ==== logic/pmem_bus_pkg.sv ====
/*
 * Memory and processor bus package.
 * Widths of the 256-bit physical memory line, the processor data word
 * and its byte enables.
 */

`default_nettype none

package pmem_bus_pkg;

    // one full cache line travels on the memory port.
    localparam int line_bits = 256;

    // processor side data word and its byte lanes.
    localparam int word_bits = 32;
    localparam int byte_bits = 8;
    localparam int be_bits = word_bits / byte_bits;

    // number of processor words held in one line.
    localparam int words_per_line = line_bits / word_bits;

endpackage : pmem_bus_pkg

`default_nettype wire

// ==== logic/cache_geom_pkg.sv ====
/*
 * Cache geometry package.
 * Address field widths, the split of the line offset into word and byte
 * selects, and the way numbering used by the LRU bits of a two-way cache.
 */

`default_nettype none

package cache_geom_pkg;

    // processor byte address width.
    localparam int addr_bits = 32;

    // a 32-byte line has five offset bits.
    localparam int offset_bits = 5;

    // low offset bits pick a byte inside a word.
    localparam int byte_sel_bits = 2;

    // the remaining offset bits pick the word inside a line.
    localparam int word_sel_bits = offset_bits - byte_sel_bits;

    // two ways per set.
    localparam int num_ways = 2;
    localparam int way_bits = 1;

    // way numbers, also the value of a set's LRU bit.
    // the LRU bit names the way that is replaced next.
    localparam logic [way_bits-1:0] way_0 = 1'b0;
    localparam logic [way_bits-1:0] way_1 = 1'b1;

endpackage : cache_geom_pkg

`default_nettype wire
